// File: project.f
source/fec_pkg.sv
source/rs_pipe_stage.sv
source/rs_encode.sv
source/rs_decode_h_select.sv
source/rs_decode.sv
source/rs_fec_top.sv
testbench/rs_fec_chk.sv
testbench/rs_fec_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --assert -j 0
TOP      = rs_fec_tb
FILELIST = project.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: sim clean

# Build, run, then decide on the pass line in the log
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -qx "Testbench passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: testbench/rs_fec_tb.sv
`timescale 1ns/10ps
`default_nettype none

module rs_fec_tb;

    import fec_pkg::*;

    // About 435 words over all tests, at most ~4 cycles each with gaps and stalls
    localparam int MAX_CYCLES = 4000;

    logic      clk = 1'b0;
    logic      rst_n;
    data_t     enc_data;
    logic      enc_valid;
    logic      enc_ready;
    codeword_t enc_cw;
    logic      enc_cw_valid;
    logic      enc_cw_ready;
    dec_in_t   dec_in;
    logic      dec_valid;
    logic      dec_ready;
    data_t     dec_data;
    logic      dec_data_valid;
    logic      dec_data_ready;

    int        cycle_count = 0;
    data_t     stim_q[$];

    always #50 clk = ~clk;

    rs_fec_top dut_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .enc_data       (enc_data),
        .enc_valid      (enc_valid),
        .enc_ready      (enc_ready),
        .enc_cw         (enc_cw),
        .enc_cw_valid   (enc_cw_valid),
        .enc_cw_ready   (enc_cw_ready),
        .dec_in         (dec_in),
        .dec_valid      (dec_valid),
        .dec_ready      (dec_ready),
        .dec_data       (dec_data),
        .dec_data_valid (dec_data_valid),
        .dec_data_ready (dec_data_ready)
    );

    // ==================================================
    // Checking
    // ==================================================
    task automatic abort_run();
        $display("Testbench failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error: %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic compare_cw(input string name, input codeword_t got, input codeword_t exp);
        if (got !== exp) begin
            $display("error: %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic compare_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            $display("error: %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d clock cycles", MAX_CYCLES);
            abort_run();
        end
    end

    // ==================================================
    // Reference model
    // ==================================================
    function automatic parity_t model_parity(input data_t d);
        parity_t p;
        p = '0;
        for (int j = 0; j < RS_2T; j++) begin
            for (int i = 0; i < RS_K; i++) begin
                p[j] ^= gf_mul(RS_GEN[j][i], d[i]);
            end
        end
        return p;
    endfunction

    // Drop the erased pair and pack what is left in position order
    function automatic data_t compress(input codeword_t cw, input int e);
        err_vec_t erased;
        data_t    s;
        int       k;
        erased = RS_ERR_LOC_LUT[e];
        s      = '0;
        k      = 0;
        for (int p = 0; p < RS_N; p++) begin
            if (!erased[p] && k < RS_K) begin
                if (p < RS_K) s[k] = cw.data[p];
                else s[k] = cw.parity[p - RS_K];
                k++;
            end
        end
        return s;
    endfunction

    // ==================================================
    // Stream drivers, each returns on the transfer edge
    // ==================================================
    task automatic push_enc(input data_t d, input int gap);
        repeat (gap) begin
            @(negedge clk);
            enc_valid = 1'b0;
        end
        @(negedge clk);
        enc_data  = d;
        enc_valid = 1'b1;
        #1;
        while (!enc_ready) begin
            @(negedge clk);
            #1;
        end
        @(posedge clk);
    endtask

    task automatic push_dec(input dec_in_t din, input int gap);
        repeat (gap) begin
            @(negedge clk);
            dec_valid = 1'b0;
        end
        @(negedge clk);
        dec_in    = din;
        dec_valid = 1'b1;
        #1;
        while (!dec_ready) begin
            @(negedge clk);
            #1;
        end
        @(posedge clk);
    endtask

    task automatic pull_cw(output codeword_t cw, input bit stall);
        do begin
            @(negedge clk);
            enc_cw_ready = stall ? ($urandom_range(0, 3) != 0) : 1'b1;
            #1;
        end while (!(enc_cw_valid && enc_cw_ready));
        cw = enc_cw;
        @(posedge clk);
    endtask

    task automatic pull_data(output data_t d, input bit stall);
        do begin
            @(negedge clk);
            dec_data_ready = stall ? ($urandom_range(0, 3) != 0) : 1'b1;
            #1;
        end while (!(dec_data_valid && dec_data_ready));
        d = dec_data;
        @(posedge clk);
    endtask

    // Encode stim_q, feed each codeword back in with an erasure, check both ends
    task automatic run_stream(input bit sweep, input bit gaps, input bit stall);
        codeword_t cw_q[$];
        codeword_t enc_got;
        codeword_t enc_exp;
        codeword_t feed_cw;
        dec_in_t   din;
        data_t     dec_got;
        int        n_items;
        int        loc;
        n_items = stim_q.size();
        fork
            begin
                for (int k = 0; k < n_items; k++) begin
                    push_enc(stim_q[k], gaps ? int'($urandom_range(0, 2)) : 0);
                end
                @(negedge clk);
                enc_valid = 1'b0;
            end
            begin
                for (int k = 0; k < n_items; k++) begin
                    pull_cw(enc_got, stall);
                    enc_exp.data   = stim_q[k];
                    enc_exp.parity = model_parity(stim_q[k]);
                    compare_cw("enc_cw", enc_got, enc_exp);
                    cw_q.push_back(enc_got);
                end
            end
            begin
                for (int k = 0; k < n_items; k++) begin
                    while (cw_q.size() == 0) begin
                        @(negedge clk);
                        dec_valid = 1'b0;
                    end
                    feed_cw       = cw_q.pop_front();
                    loc           = sweep ? (k % NUM_H) : int'($urandom_range(0, NUM_H - 1));
                    din.survivors = compress(feed_cw, loc);
                    din.err_loc   = err_loc_t'(loc);
                    push_dec(din, gaps ? int'($urandom_range(0, 2)) : 0);
                end
                @(negedge clk);
                dec_valid = 1'b0;
            end
            begin
                for (int k = 0; k < n_items; k++) begin
                    pull_data(dec_got, stall);
                    compare_data("dec_data", dec_got, stim_q[k]);
                end
            end
        join
    endtask

    // ==================================================
    // Tests
    // ==================================================
    task automatic test_reset();
        rst_n = 1'b0;
        repeat (8) begin
            @(negedge clk);
            compare_bit("enc_cw_valid", enc_cw_valid, 1'b0);
            compare_bit("dec_data_valid", dec_data_valid, 1'b0);
        end
        rst_n = 1'b1;
        @(negedge clk);
        compare_bit("enc_cw_valid", enc_cw_valid, 1'b0);
        compare_bit("dec_data_valid", dec_data_valid, 1'b0);
        compare_bit("enc_ready", enc_ready, 1'b1);
        compare_bit("dec_ready", dec_ready, 1'b1);
    endtask

    task automatic test_encoder();
        stim_q = '{32'h0000_0000, 32'hFFFF_FFFF, 32'h0403_0201, 32'h1020_4080};
        repeat (16) stim_q.push_back($urandom);
        run_stream(1'b1, 1'b0, 1'b0);
    endtask

    task automatic test_all_patterns();
        stim_q.delete();
        repeat (NUM_H) stim_q.push_back($urandom);
        run_stream(1'b1, 1'b0, 1'b0);
    endtask

    task automatic test_streaming(input bit stall);
        stim_q.delete();
        repeat (200) stim_q.push_back($urandom);
        run_stream(1'b0, 1'b1, stall);
    endtask

    initial begin
        rst_n          = 1'b0;
        enc_data       = '0;
        enc_valid      = 1'b0;
        enc_cw_ready   = 1'b0;
        dec_in         = '0;
        dec_valid      = 1'b0;
        dec_data_ready = 1'b0;
        void'($urandom(32'h733873fa));

        test_reset();
        test_encoder();
        test_all_patterns();
        test_streaming(1'b0);
        test_streaming(1'b1);

        repeat (2) @(negedge clk);
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/rs_fec_chk.sv
`timescale 1ns/10ps
`default_nettype none

module rs_fec_chk (
    input wire                     clk,
    input wire                     rst_n,
    input wire fec_pkg::codeword_t enc_cw,
    input wire                     enc_cw_valid,
    input wire                     enc_cw_ready,
    input wire fec_pkg::dec_in_t   dec_in,
    input wire                     dec_valid,
    input wire fec_pkg::hsel_t     hsel,
    input wire                     hsel_valid,
    input wire fec_pkg::data_t     dec_data,
    input wire                     dec_data_valid,
    input wire                     dec_data_ready
);

    import fec_pkg::*;

    // ==================================================
    // Stalled outputs hold still
    // ==================================================
    a_enc_cw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        enc_cw_valid && !enc_cw_ready |=> enc_cw_valid && $stable(enc_cw))
        else $error("enc_cw dropped or changed while stalled");

    a_dec_data_hold: assert property (@(posedge clk) disable iff (!rst_n)
        dec_data_valid && !dec_data_ready |=> dec_data_valid && $stable(dec_data))
        else $error("dec_data dropped or changed while stalled");

    // Only indices with a table entry
    a_err_loc_range: assert property (@(posedge clk) disable iff (!rst_n)
        dec_valid |-> dec_in.err_loc < err_loc_t'(NUM_H))
        else $error("dec_in.err_loc out of range");

    // Every pattern erases exactly RS_2T positions
    a_err_vec_count: assert property (@(posedge clk) disable iff (!rst_n)
        hsel_valid |-> $countones(hsel.err_vec) == RS_2T)
        else $error("hsel.err_vec does not flag RS_2T erased positions");

    // Valids stay low while reset is held
    a_reset_valid: assert property (@(posedge clk)
        !rst_n |=> !enc_cw_valid && !hsel_valid && !dec_data_valid)
        else $error("valid output high during reset");

endmodule

bind rs_fec_top rs_fec_chk chk_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .enc_cw         (enc_cw),
    .enc_cw_valid   (enc_cw_valid),
    .enc_cw_ready   (enc_cw_ready),
    .dec_in         (dec_in),
    .dec_valid      (dec_valid),
    .hsel           (hsel),
    .hsel_valid     (hsel_valid),
    .dec_data       (dec_data),
    .dec_data_valid (dec_data_valid),
    .dec_data_ready (dec_data_ready)
);

`default_nettype wire

// File: source/rs_fec_top.sv
`timescale 1ns/10ps
`default_nettype none

module rs_fec_top (
    input  wire                   clk,
    input  wire                   rst_n,

    // Encoder input
    input  wire fec_pkg::data_t   enc_data,
    input  wire                   enc_valid,
    output logic                  enc_ready,

    // Encoder output
    output fec_pkg::codeword_t    enc_cw,
    output logic                  enc_cw_valid,
    input  wire                   enc_cw_ready,

    // Decoder input, survivors already compressed
    input  wire fec_pkg::dec_in_t dec_in,
    input  wire                   dec_valid,
    output logic                  dec_ready,

    // Decoder output
    output fec_pkg::data_t        dec_data,
    output logic                  dec_data_valid,
    input  wire                   dec_data_ready
);

    import fec_pkg::*;

    // ==================================================
    // Encoder branch
    // ==================================================
    rs_encode u_encode (
        .clk           (clk),
        .rst_n         (rst_n),
        .data_in       (enc_data),
        .data_in_valid (enc_valid),
        .data_in_ready (enc_ready),
        .cw_out        (enc_cw),
        .cw_out_valid  (enc_cw_valid),
        .cw_out_ready  (enc_cw_ready)
    );

    // ==================================================
    // Decoder pipeline
    // ==================================================
    hsel_t hsel;
    logic  hsel_valid;
    logic  hsel_ready;

    rs_decode_h_select u_h_select (
        .clk          (clk),
        .rst_n        (rst_n),
        .dec_in       (dec_in),
        .dec_in_valid (dec_valid),
        .dec_in_ready (dec_ready),
        .hsel_out     (hsel),
        .hsel_valid   (hsel_valid),
        .hsel_ready   (hsel_ready)
    );

    rs_decode u_decode (
        .clk            (clk),
        .rst_n          (rst_n),
        .hsel_in        (hsel),
        .hsel_valid     (hsel_valid),
        .hsel_ready     (hsel_ready),
        .data_out       (dec_data),
        .data_out_valid (dec_data_valid),
        .data_out_ready (dec_data_ready)
    );

endmodule

`default_nettype wire

// File: source/rs_decode.sv
`timescale 1ns/10ps
`default_nettype none

// Second decoder stage, data = H * survivors
module rs_decode (
    input  wire                 clk,
    input  wire                 rst_n,

    input  wire fec_pkg::hsel_t hsel_in,
    input  wire                 hsel_valid,
    output logic                hsel_ready,

    output fec_pkg::data_t      data_out,
    output logic                data_out_valid,
    input  wire                 data_out_ready
);

    import fec_pkg::*;

    data_t data_next;

    // ==================================================
    // Matrix times vector over GF(2^8)
    // ==================================================
    always_comb begin
        data_next = '0;
        for (int r = 0; r < RS_K; r++) begin
            for (int c = 0; c < RS_K; c++) begin
                data_next[r] ^= gf_mul(hsel_in.h_matrix[r][c], hsel_in.survivors[c]);
            end
        end
    end

    // Output register
    rs_pipe_stage #(
        .payload_t (data_t)
    ) u_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_data   (data_next),
        .in_valid  (hsel_valid),
        .in_ready  (hsel_ready),
        .out_data  (data_out),
        .out_valid (data_out_valid),
        .out_ready (data_out_ready)
    );

endmodule

`default_nettype wire

// File: source/rs_decode_h_select.sv
`timescale 1ns/10ps
`default_nettype none

// First decoder stage, erasure index to inverse matrix
module rs_decode_h_select (
    input  wire                  clk,
    input  wire                  rst_n,

    input  wire fec_pkg::dec_in_t dec_in,
    input  wire                  dec_in_valid,
    output logic                 dec_in_ready,

    output fec_pkg::hsel_t       hsel_out,
    output logic                 hsel_valid,
    input  wire                  hsel_ready
);

    import fec_pkg::*;

    hsel_t    hsel_next;
    logic     loc_ok;

    // Indices past the last pattern have no table entry
    assign loc_ok = (dec_in.err_loc < err_loc_t'(NUM_H));

    // ==================================================
    // Table lookup
    // ==================================================
    always_comb begin
        hsel_next.survivors = dec_in.survivors;
        if (loc_ok) begin
            hsel_next.h_matrix = RS_H_LUT[dec_in.err_loc];
            hsel_next.err_vec  = RS_ERR_LOC_LUT[dec_in.err_loc];
        end else begin
            // Zero matrix yields zero data
            hsel_next.h_matrix = '0;
            hsel_next.err_vec  = '0;
        end
    end

    rs_pipe_stage #(
        .payload_t (hsel_t)
    ) u_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_data   (hsel_next),
        .in_valid  (dec_in_valid),
        .in_ready  (dec_in_ready),
        .out_data  (hsel_out),
        .out_valid (hsel_valid),
        .out_ready (hsel_ready)
    );

endmodule

`default_nettype wire

// File: source/rs_encode.sv
`timescale 1ns/10ps
`default_nettype none

module rs_encode (
    input  wire                 clk,
    input  wire                 rst_n,

    input  wire fec_pkg::data_t data_in,
    input  wire                 data_in_valid,
    output logic                data_in_ready,

    output fec_pkg::codeword_t  cw_out,
    output logic                cw_out_valid,
    input  wire                 cw_out_ready
);

    import fec_pkg::*;

    codeword_t cw_next;

    // ==================================================
    // Parity from the Cauchy generator
    // ==================================================
    always_comb begin
        cw_next.data   = data_in;
        cw_next.parity = '0;
        for (int j = 0; j < RS_2T; j++) begin
            for (int i = 0; i < RS_K; i++) begin
                cw_next.parity[j] ^= gf_mul(RS_GEN[j][i], data_in[i]);
            end
        end
    end

    // Codeword register
    rs_pipe_stage #(
        .payload_t (codeword_t)
    ) u_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_data   (cw_next),
        .in_valid  (data_in_valid),
        .in_ready  (data_in_ready),
        .out_data  (cw_out),
        .out_valid (cw_out_valid),
        .out_ready (cw_out_ready)
    );

endmodule

`default_nettype wire

// File: source/rs_pipe_stage.sv
`timescale 1ns/10ps
`default_nettype none

// Single register slice with valid/ready handshake
module rs_pipe_stage #(
    parameter type payload_t = logic
) (
    input  wire           clk,
    input  wire           rst_n,

    input  wire payload_t in_data,
    input  wire           in_valid,
    output logic          in_ready,

    output payload_t      out_data,
    output logic          out_valid,
    input  wire           out_ready
);

    // Accept when empty or when the held item leaves this cycle
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    // Payload only moves on a transfer
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_data <= in_data;
        end
    end

endmodule

`default_nettype wire

// File: source/fec_pkg.sv
`default_nettype none

package fec_pkg;

    // ==================================================
    // Code dimensions
    // ==================================================
    localparam int SYM_SIZE  = 8;
    localparam int RS_K      = 4;
    localparam int RS_2T     = 2;
    localparam int RS_N      = RS_K + RS_2T;
    // Pairs of erased positions out of RS_N
    localparam int NUM_H     = RS_N * (RS_N - 1) / 2;
    localparam int ERR_LOC_W = $clog2(NUM_H);

    // Field polynomial x^8 + x^4 + x^3 + x^2 + 1
    localparam logic [SYM_SIZE:0] GF_POLY = 9'h11D;

    // ==================================================
    // Types
    // ==================================================
    typedef logic [SYM_SIZE-1:0]                        sym_t;
    typedef logic [RS_K-1:0][SYM_SIZE-1:0]              data_t;
    typedef logic [RS_2T-1:0][SYM_SIZE-1:0]             parity_t;
    typedef logic [ERR_LOC_W-1:0]                       err_loc_t;
    typedef logic [RS_N-1:0]                            err_vec_t;
    typedef logic [RS_K-1:0][RS_K-1:0][SYM_SIZE-1:0]    h_matrix_t;
    typedef logic [RS_2T-1:0][RS_K-1:0][SYM_SIZE-1:0]   gen_matrix_t;
    typedef err_vec_t  [NUM_H-1:0]                      err_lut_t;
    typedef h_matrix_t [NUM_H-1:0]                      h_lut_t;

    // Position i is data[i] below RS_K, parity[i-RS_K] above
    typedef struct packed {
        parity_t parity;
        data_t   data;
    } codeword_t;

    typedef struct packed {
        data_t    survivors;
        err_loc_t err_loc;
    } dec_in_t;

    typedef struct packed {
        data_t     survivors;
        h_matrix_t h_matrix;
        err_vec_t  err_vec;
    } hsel_t;

    // ==================================================
    // GF(2^8) arithmetic
    // ==================================================
    function automatic sym_t gf_mul(input sym_t a, input sym_t b);
        sym_t acc;
        sym_t sh;
        acc = '0;
        sh  = a;
        for (int i = 0; i < SYM_SIZE; i++) begin
            if (b[i]) acc ^= sh;
            // Multiply by x and reduce
            sh = sh[SYM_SIZE-1] ? ((sh << 1) ^ GF_POLY[SYM_SIZE-1:0]) : (sh << 1);
        end
        return acc;
    endfunction

    // a^254 built from the squares a^2 .. a^128, zero maps to zero
    function automatic sym_t gf_inv(input sym_t a);
        sym_t sq;
        sym_t r;
        sq = a;
        r  = 8'd1;
        for (int k = 1; k < SYM_SIZE; k++) begin
            sq = gf_mul(sq, sq);
            r  = gf_mul(r, sq);
        end
        return r;
    endfunction

    // ==================================================
    // Constant tables
    // ==================================================
    // Cauchy parity rows
    function automatic gen_matrix_t make_rs_gen();
        gen_matrix_t g;
        for (int j = 0; j < RS_2T; j++) begin
            for (int i = 0; i < RS_K; i++) begin
                g[j][i] = gf_inv(sym_t'(j + RS_K) ^ sym_t'(i));
            end
        end
        return g;
    endfunction

    localparam gen_matrix_t RS_GEN = make_rs_gen();

    // Erased pairs (a, b) with a < b in lexicographic order
    function automatic err_lut_t make_err_loc_lut();
        err_lut_t lut;
        int       e;
        lut = '0;
        e   = 0;
        for (int a = 0; a < RS_N; a++) begin
            for (int b = a + 1; b < RS_N; b++) begin
                lut[e][a] = 1'b1;
                lut[e][b] = 1'b1;
                e++;
            end
        end
        return lut;
    endfunction

    localparam err_lut_t RS_ERR_LOC_LUT = make_err_loc_lut();

    // Inverse of the surviving generator rows via Gauss-Jordan
    function automatic h_matrix_t make_h_matrix(input err_vec_t erased);
        h_matrix_t m;
        h_matrix_t inv;
        sym_t      piv;
        sym_t      f;
        sym_t      tmp;
        int        row;
        int        sel;
        m   = '0;
        inv = '0;
        row = 0;
        for (int p = 0; p < RS_N; p++) begin
            if (!erased[p] && row < RS_K) begin
                if (p < RS_K) m[row][p] = 8'd1;
                else m[row] = RS_GEN[p-RS_K];
                row++;
            end
        end
        for (int k = 0; k < RS_K; k++) inv[k][k] = 8'd1;

        for (int k = 0; k < RS_K; k++) begin
            // Lowest row at or below k with a nonzero pivot
            sel = k;
            for (int r = RS_K - 1; r >= k; r--) begin
                if (m[r][k] != '0) sel = r;
            end
            for (int c = 0; c < RS_K; c++) begin
                tmp         = m[k][c];
                m[k][c]     = m[sel][c];
                m[sel][c]   = tmp;
                tmp         = inv[k][c];
                inv[k][c]   = inv[sel][c];
                inv[sel][c] = tmp;
            end
            piv = gf_inv(m[k][k]);
            for (int c = 0; c < RS_K; c++) begin
                m[k][c]   = gf_mul(m[k][c], piv);
                inv[k][c] = gf_mul(inv[k][c], piv);
            end
            for (int r = 0; r < RS_K; r++) begin
                if (r != k) begin
                    f = m[r][k];
                    for (int c = 0; c < RS_K; c++) begin
                        m[r][c]   ^= gf_mul(f, m[k][c]);
                        inv[r][c] ^= gf_mul(f, inv[k][c]);
                    end
                end
            end
        end
        return inv;
    endfunction

    function automatic h_lut_t make_h_lut();
        h_lut_t lut;
        for (int e = 0; e < NUM_H; e++) begin
            lut[e] = make_h_matrix(RS_ERR_LOC_LUT[e]);
        end
        return lut;
    endfunction

    localparam h_lut_t RS_H_LUT = make_h_lut();

endpackage

`default_nettype wire
